//--- hdl/aud_mem_pkg.sv
`default_nettype none

package aud_mem_pkg;

    // one SRAM word holds one signed audio sample
    typedef logic signed [15:0] sample_t;

    // SRAM word address
    typedef logic [19:0] addr_t;

    localparam addr_t START_ADDR = '0;           // playback always begins here

    // full SRAM size in words, 2^20
    localparam int DEFAULT_MEM_WORDS = 1048576;

    // clocks from the detected LRC fall to the sample tick
    // gives the SRAM read data time to settle
    localparam int TICK_DELAY = 2;

endpackage

`default_nettype wire

//--- hdl/aud_speed_pkg.sv
`default_nettype none

package aud_speed_pkg;

    // speed code fields
    // bits 6:3 fast step 1..8, bits 2:0 slow code c for divisor c+1, bit 7 unused
    typedef logic [7:0] speed_t;

    localparam int FAST_HI = 6;
    localparam int FAST_LO = 3;
    localparam int SLOW_HI = 2;
    localparam int SLOW_LO = 0;

    typedef logic [2:0] sub_cnt_t;               // position k inside one slow period
    typedef logic [3:0] weight_t;                // 0..8

    localparam int WEIGHT_SCALE_SHIFT = 3;       // weights are in eighths

    // weight of the newer sample, floor(8*k/N), rows by divisor N and columns by k
    localparam weight_t WEIGHT_TABLE [1:8][0:7] = '{
        '{4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0},
        '{4'd0, 4'd4, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0},
        '{4'd0, 4'd2, 4'd5, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0},
        '{4'd0, 4'd2, 4'd4, 4'd6, 4'd0, 4'd0, 4'd0, 4'd0},
        '{4'd0, 4'd1, 4'd3, 4'd4, 4'd6, 4'd0, 4'd0, 4'd0},
        '{4'd0, 4'd1, 4'd2, 4'd4, 4'd5, 4'd6, 4'd0, 4'd0},
        '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd0},
        '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7}
    };

    typedef enum logic [1:0] {
        IDLE,
        PLAY,
        PAUSE,
        STOP
    } play_state_t;

    // slow playback only when no fast step is given
    function automatic logic is_slow(speed_t speed);
        return (speed[FAST_HI:FAST_LO] == '0) && (speed[SLOW_HI:SLOW_LO] != '0);
    endfunction

endpackage

`default_nettype wire

//--- hdl/aud_lrck_sync.sv
`timescale 1ns/100ps
`default_nettype none

module aud_lrck_sync (
    input  wire  i_clk,
    input  wire  i_rst_n,
    input  wire  i_daclrck,
    output logic o_tick
);

    localparam int CNT_W = $clog2(aud_mem_pkg::TICK_DELAY + 1);

    logic             lrck_meta;
    logic             lrck_sync;
    logic             lrck_prev;
    logic             lrck_fall;
    logic [CNT_W-1:0] delay_cnt;

    // left channel starts on the falling edge
    assign lrck_fall = lrck_prev & ~lrck_sync;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lrck_meta <= 1'b0;
            lrck_sync <= 1'b0;
            lrck_prev <= 1'b0;
            delay_cnt <= '0;
        end else begin
            lrck_meta <= i_daclrck;
            lrck_sync <= lrck_meta;
            lrck_prev <= lrck_sync;
            if (lrck_fall) begin
                delay_cnt <= CNT_W'(aud_mem_pkg::TICK_DELAY);
            end else if (delay_cnt != '0) begin
                delay_cnt <= delay_cnt - 1'b1;       // wait for SRAM data to settle
            end
        end
    end

    // one cycle strobe on the last count
    assign o_tick = (delay_cnt == CNT_W'(1));

endmodule

`default_nettype wire

//--- hdl/aud_play_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module aud_play_ctrl (
    input  wire  i_clk,
    input  wire  i_rst_n,
    input  wire  i_start,
    input  wire  i_pause,
    input  wire  i_stop,
    input  wire  i_done,
    input  wire  i_tick,
    input  wire  i_player_ack,
    output logic o_play,
    output logic o_clear,
    output logic o_player_en
);

    aud_speed_pkg::play_state_t state;
    aud_speed_pkg::play_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            aud_speed_pkg::IDLE: begin
                if (i_start) begin
                    state_nxt = aud_speed_pkg::PLAY;
                end
            end
            aud_speed_pkg::PLAY: begin
                if (i_stop) begin
                    state_nxt = aud_speed_pkg::STOP;
                end else if (i_pause) begin
                    state_nxt = aud_speed_pkg::PAUSE;
                end else if (i_done) begin
                    state_nxt = aud_speed_pkg::IDLE;   // end of memory, address stays
                end
            end
            aud_speed_pkg::PAUSE: begin
                if (i_start) begin
                    state_nxt = aud_speed_pkg::PLAY;   // resume where we left off
                end else if (i_stop) begin
                    state_nxt = aud_speed_pkg::STOP;
                end
            end
            aud_speed_pkg::STOP: begin
                state_nxt = aud_speed_pkg::IDLE;
            end
            default: begin
                state_nxt = aud_speed_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= aud_speed_pkg::IDLE;
            o_player_en <= 1'b0;
        end else begin
            state <= state_nxt;
            // pause and stop win over a new sample
            if (i_pause || i_stop) begin
                o_player_en <= 1'b0;
            end else if (i_tick && state == aud_speed_pkg::PLAY) begin
                o_player_en <= 1'b1;                  // new sample for the player
            end else if (i_player_ack) begin
                o_player_en <= 1'b0;
            end
        end
    end

    assign o_play  = (state == aud_speed_pkg::PLAY);
    assign o_clear = (state == aud_speed_pkg::STOP); // single cycle, STOP always exits

endmodule

`default_nettype wire

//--- hdl/aud_addr_gen.sv
`timescale 1ns/100ps
`default_nettype none

module aud_addr_gen #(
    parameter int MEM_WORDS = aud_mem_pkg::DEFAULT_MEM_WORDS
) (
    input  wire                      i_clk,
    input  wire                      i_rst_n,
    input  wire                      i_tick,
    input  wire                      i_play,
    input  wire                      i_clear,
    input  wire aud_speed_pkg::speed_t i_speed,
    input  wire                      i_linear,
    output aud_mem_pkg::addr_t       o_addr,
    output aud_speed_pkg::sub_cnt_t  o_sub_cnt,
    output logic                     o_step_new,
    output logic                     o_done
);

    localparam int ADDR_W = $bits(aud_mem_pkg::addr_t);
    localparam logic [ADDR_W:0] LAST_ADDR = (ADDR_W + 1)'(MEM_WORDS - 1);

    logic [3:0]              fast_step;
    aud_speed_pkg::sub_cnt_t slow_code;       // N - 1
    logic                    slow;
    logic                    advance;
    logic                    past_end;
    logic                    step_event;
    aud_mem_pkg::addr_t      step;
    logic [ADDR_W:0]         addr_sum;
    aud_speed_pkg::sub_cnt_t sub_cnt_nxt;

    assign fast_step = i_speed[aud_speed_pkg::FAST_HI:aud_speed_pkg::FAST_LO];
    assign slow_code = i_speed[aud_speed_pkg::SLOW_HI:aud_speed_pkg::SLOW_LO];
    assign slow      = aud_speed_pkg::is_slow(i_speed);

    always_comb begin
        // all-zero code plays at normal speed
        step = aud_mem_pkg::addr_t'(1);
        if (!slow && fast_step != '0) begin
            step = aud_mem_pkg::addr_t'(fast_step);
        end

        if (!slow) begin
            advance = 1'b1;                       // fast, every tick
        end else if (i_linear) begin
            advance = (o_sub_cnt == '0);          // step first, then interpolate toward it
        end else begin
            advance = (o_sub_cnt == slow_code);   // hold, step on the last repeat
        end

        if (!slow || o_sub_cnt == slow_code) begin
            sub_cnt_nxt = '0;
        end else begin
            sub_cnt_nxt = o_sub_cnt + 1'b1;
        end
    end

    assign addr_sum   = {1'b0, o_addr} + {1'b0, step};
    assign past_end   = (addr_sum > LAST_ADDR);
    assign step_event = i_tick & i_play;

    assign o_step_new = step_event & advance & ~past_end;
    assign o_done     = step_event & advance & past_end;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_addr    <= aud_mem_pkg::START_ADDR;
            o_sub_cnt <= '0;
        end else if (i_clear) begin
            o_addr    <= aud_mem_pkg::START_ADDR;
            o_sub_cnt <= '0;
        end else if (step_event && !o_done) begin   // everything freezes at the end
            if (advance) begin
                o_addr <= addr_sum[ADDR_W-1:0];
            end
            o_sub_cnt <= sub_cnt_nxt;
        end
    end

endmodule

`default_nettype wire

//--- hdl/aud_interp.sv
`timescale 1ns/100ps
`default_nettype none

module aud_interp (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wire                        i_tick,
    input  wire                        i_play,
    input  wire                        i_linear,
    input  wire aud_speed_pkg::speed_t   i_speed,
    input  wire aud_speed_pkg::sub_cnt_t i_sub_cnt,
    input  wire                        i_step_new,
    input  wire aud_mem_pkg::sample_t    i_sram_data,
    output aud_mem_pkg::sample_t         o_dac_data
);

    localparam aud_speed_pkg::weight_t W_FULL =
        aud_speed_pkg::weight_t'(1 << aud_speed_pkg::WEIGHT_SCALE_SHIFT);

    aud_mem_pkg::sample_t   held_sample;      // sample at the address last left
    logic [3:0]             divisor;
    aud_speed_pkg::weight_t weight;
    aud_speed_pkg::weight_t weight_inv;
    logic signed [21:0]     mix_sum;
    logic                   mix_sel;
    aud_mem_pkg::sample_t   next_sample;

    assign divisor    = {1'b0, i_speed[aud_speed_pkg::SLOW_HI:aud_speed_pkg::SLOW_LO]} + 4'd1;
    assign weight     = aud_speed_pkg::WEIGHT_TABLE[divisor][i_sub_cnt];
    assign weight_inv = W_FULL - weight;

    // k = 0 passes the sample through unweighted
    assign mix_sel = aud_speed_pkg::is_slow(i_speed) & i_linear & (i_sub_cnt != '0);

    always_comb begin
        mix_sum = i_sram_data * $signed({1'b0, weight})
                + held_sample * $signed({1'b0, weight_inv});
        if (mix_sel) begin
            next_sample = aud_mem_pkg::sample_t'(mix_sum >>> aud_speed_pkg::WEIGHT_SCALE_SHIFT);
        end else begin
            next_sample = i_sram_data;            // fast and hold modes
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_tick && i_play && i_step_new) begin
            held_sample <= i_sram_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dac_data <= '0;
        end else if (i_tick && i_play) begin
            o_dac_data <= next_sample;
        end
    end

endmodule

`default_nettype wire

//--- hdl/aud_dsp_top.sv
`timescale 1ns/100ps
`default_nettype none

module aud_dsp_top #(
    parameter int MEM_WORDS = aud_mem_pkg::DEFAULT_MEM_WORDS
) (
    input  wire                      i_clk,
    input  wire                      i_rst_n,
    input  wire                      i_start,
    input  wire                      i_pause,
    input  wire                      i_stop,
    input  wire aud_speed_pkg::speed_t i_speed,
    input  wire                      i_linear,
    input  wire                      i_daclrck,
    input  wire aud_mem_pkg::sample_t  i_sram_data,
    input  wire                      i_player_ack,
    output aud_mem_pkg::sample_t       o_dac_data,
    output aud_mem_pkg::addr_t         o_sram_addr,
    output logic                     o_player_en
);

    logic                    tick;
    logic                    play;
    logic                    clear;
    logic                    done;
    logic                    step_new;
    aud_speed_pkg::sub_cnt_t sub_cnt;

    aud_lrck_sync u_lrck_sync (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_daclrck (i_daclrck),
        .o_tick    (tick)
    );

    aud_play_ctrl u_play_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_pause      (i_pause),
        .i_stop       (i_stop),
        .i_done       (done),
        .i_tick       (tick),
        .i_player_ack (i_player_ack),
        .o_play       (play),
        .o_clear      (clear),
        .o_player_en  (o_player_en)
    );

    aud_addr_gen #(
        .MEM_WORDS (MEM_WORDS)
    ) u_addr_gen (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_tick     (tick),
        .i_play     (play),
        .i_clear    (clear),
        .i_speed    (i_speed),
        .i_linear   (i_linear),
        .o_addr     (o_sram_addr),
        .o_sub_cnt  (sub_cnt),
        .o_step_new (step_new),
        .o_done     (done)
    );

    // SRAM is combinational, data follows o_sram_addr
    aud_interp u_interp (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_tick      (tick),
        .i_play      (play),
        .i_linear    (i_linear),
        .i_speed     (i_speed),
        .i_sub_cnt   (sub_cnt),
        .i_step_new  (step_new),
        .i_sram_data (i_sram_data),
        .o_dac_data  (o_dac_data)
    );

endmodule

`default_nettype wire

//--- test/tb_aud_sram.sv
`timescale 1ns/100ps
`default_nettype none

module tb_aud_sram (
    input  wire                  i_clk,
    input  wire                  i_rst_n,
    input  wire aud_mem_pkg::addr_t i_addr,
    output aud_mem_pkg::sample_t o_data,
    output logic                 o_daclrck
);

    localparam int LRCK_HALF = 8;                // LR clock period is 16 clocks

    logic [3:0] lrck_cnt;
    int         data_full;

    // combinational read, a pattern that depends on the whole address
    always_comb begin
        data_full = int'(i_addr) * 1237 - 20000;
        o_data    = aud_mem_pkg::sample_t'(data_full);
    end

    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lrck_cnt  <= '0;
            o_daclrck <= 1'b1;
        end else begin
            if (lrck_cnt == LRCK_HALF - 1) begin
                lrck_cnt  <= '0;
                o_daclrck <= ~o_daclrck;     // falling edge starts the left channel
            end else begin
                lrck_cnt <= lrck_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_aud_dsp.sv
`timescale 1ns/100ps
`default_nettype none

module tb_aud_dsp;

    localparam int MEM_WORDS = 64;
    localparam int UPD_TIMEOUT = 40;             // wait limit in clocks covers two LR periods

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_start;
    logic                  i_pause;
    logic                  i_stop;
    aud_speed_pkg::speed_t i_speed;
    logic                  i_linear;
    logic                  i_player_ack;
    wire                   daclrck;
    aud_mem_pkg::sample_t  sram_data;
    aud_mem_pkg::sample_t  o_dac_data;
    aud_mem_pkg::addr_t    o_sram_addr;
    logic                  o_player_en;

    int err_cnt;
    int pass_cnt;
    int fail_cnt;

    aud_dsp_top #(.MEM_WORDS(MEM_WORDS)) dut (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start), .i_pause(i_pause),
        .i_stop(i_stop), .i_speed(i_speed), .i_linear(i_linear), .i_daclrck(daclrck),
        .i_sram_data(sram_data), .i_player_ack(i_player_ack),
        .o_dac_data(o_dac_data), .o_sram_addr(o_sram_addr), .o_player_en(o_player_en)
    );

    tb_aud_sram u_sram (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_addr(o_sram_addr),
        .o_data(sram_data), .o_daclrck(daclrck)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // expected SRAM content
    function automatic aud_mem_pkg::sample_t sample_at(input int a);
        return aud_mem_pkg::sample_t'(a * 1237 - 20000);
    endfunction

    // linear mix with the newer sample weighted floor(8k/N)
    function automatic aud_mem_pkg::sample_t mix_expect(input int old_s, input int new_s,
                                                        input int k, input int n);
        int w;
        int sum;
        w   = (8 * k) / n;
        sum = new_s * w + old_s * (8 - w);
        return aud_mem_pkg::sample_t'(sum >>> 3);
    endfunction

    task automatic expect_true(input bit ok, input string msg);
        assert (ok) else begin
            $display("ERR %0t: %s", $time, msg);
            err_cnt++;
        end
    endtask

    // one output update shows as a rising o_player_en
    task automatic wait_update();
        bit prev;
        bit seen;
        int n;
        prev = o_player_en;
        seen = 1'b0;
        n = 0;
        while (!seen && n < UPD_TIMEOUT) begin
            @(negedge i_clk);
            seen = o_player_en && !prev;
            prev = o_player_en;
            n++;
        end
        if (!seen) begin
            $display("timeout: no output update within %0d clocks", UPD_TIMEOUT);
            err_cnt++;
        end
    endtask

    task automatic pulse(input int which);
        @(posedge i_clk);
        case (which)
            0: i_start <= 1'b1;
            1: i_pause <= 1'b1;
            default: i_stop <= 1'b1;
        endcase
        @(posedge i_clk);
        i_start <= 1'b0;
        i_pause <= 1'b0;
        i_stop  <= 1'b0;
    endtask

    task automatic restart(input aud_speed_pkg::speed_t speed, input bit linear);
        pulse(2);
        @(posedge i_clk);
        i_speed  <= speed;
        i_linear <= linear;
        @(negedge i_clk);
        expect_true(o_sram_addr == 0, "address not zero before start");
        pulse(0);
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (err_cnt == err_before) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: fail (%0d errors)", name, err_cnt - err_before);
        end
    endtask

    // player side acknowledges each sample after a random delay
    initial begin : ack_driver
        int delay;
        void'($urandom(5));
        forever begin
            @(negedge i_clk);
            if (o_player_en) begin
                delay = $urandom_range(4, 1);
                repeat (delay) @(posedge i_clk);
                i_player_ack <= 1'b1;
                @(posedge i_clk);
                i_player_ack <= 1'b0;
                @(negedge i_clk);
                expect_true(!o_player_en, "player enable still high after ack");
            end
        end
    end

    initial begin
        int e0;
        int a;
        int k;
        int held_addr;
        aud_mem_pkg::sample_t held_data;
        err_cnt = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        i_rst_n = 1'b0;
        i_start = 1'b0;
        i_pause = 1'b0;
        i_stop = 1'b0;
        i_speed = '0;
        i_linear = 1'b0;
        i_player_ack = 1'b0;
        repeat (5) @(posedge i_clk);
        i_rst_n <= 1'b1;

        e0 = err_cnt;                            // reset values
        @(negedge i_clk);
        expect_true(o_player_en == 0, "player enable not zero after reset");
        expect_true(o_dac_data == 0, "dac data not zero after reset");
        expect_true(o_sram_addr == 0, "address not zero after reset");
        finish_test("reset", e0);

        e0 = err_cnt;                            // fast step 3
        restart(8'h18, 1'b0);
        for (int i = 0; i < 8; i++) begin
            wait_update();
            expect_true(o_sram_addr == 3 * (i + 1), "fast address step is not 3");
            expect_true(o_dac_data == sample_at(3 * i), "fast sample mismatch");
        end
        finish_test("fast_playback", e0);

        e0 = err_cnt;                            // hold mode with N = 4
        restart(8'h03, 1'b0);
        for (int i = 0; i < 12; i++) begin
            wait_update();
            a = i / 4;
            expect_true(o_dac_data == sample_at(a), "hold sample mismatch");
            expect_true(o_sram_addr == ((i % 4 == 3) ? a + 1 : a), "hold address wrong");
        end
        finish_test("slow_hold", e0);

        e0 = err_cnt;                            // linear mode with N = 4
        restart(8'h03, 1'b1);
        for (int i = 0; i < 12; i++) begin
            wait_update();
            a = i / 4;
            k = i % 4;
            expect_true(o_sram_addr == a + 1, "linear address wrong");
            if (k == 0) begin
                expect_true(o_dac_data == sample_at(a), "linear k=0 sample mismatch");
            end else begin
                expect_true(o_dac_data == mix_expect(sample_at(a), sample_at(a + 1), k, 4),
                            "linear mix mismatch");
            end
        end
        finish_test("slow_linear", e0);

        e0 = err_cnt;                            // pause and resume followed by stop
        restart(8'h08, 1'b0);
        repeat (3) wait_update();
        pulse(1);
        @(negedge i_clk);
        held_addr = o_sram_addr;
        held_data = o_dac_data;
        repeat (2 * UPD_TIMEOUT) begin
            @(negedge i_clk);
            expect_true(o_sram_addr == held_addr, "address moved during pause");
            expect_true(!o_player_en, "player enable high during pause");
        end
        expect_true(o_dac_data == held_data, "dac data changed during pause");
        pulse(0);
        wait_update();
        expect_true(o_sram_addr == held_addr + 1, "resume did not continue stepping");
        expect_true(o_dac_data == sample_at(held_addr), "resume sample mismatch");
        pulse(2);
        repeat (2) @(negedge i_clk);
        expect_true(o_sram_addr == 0, "address not zero after stop");
        finish_test("pause_resume_stop", e0);

        e0 = err_cnt;                            // end of memory at step 1
        restart(8'h08, 1'b0);
        k = 0;
        while (o_sram_addr != MEM_WORDS - 1 && k < MEM_WORDS + 4) begin
            wait_update();
            k++;
        end
        expect_true(o_sram_addr == MEM_WORDS - 1, "last address not reached");
        wait_update();                           // last sample plays while the address holds
        expect_true(o_dac_data == sample_at(MEM_WORDS - 1), "last sample mismatch");
        repeat (5 * 16) begin
            @(negedge i_clk);
            expect_true(o_sram_addr == MEM_WORDS - 1, "address moved after end");
            expect_true(o_dac_data == sample_at(MEM_WORDS - 1), "data moved after end");
        end
        finish_test("end_of_memory", e0);

        $display("tests %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt,
                 fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hdl/aud_mem_pkg.sv
hdl/aud_speed_pkg.sv
hdl/aud_lrck_sync.sv
hdl/aud_play_ctrl.sv
hdl/aud_addr_gen.sv
hdl/aud_interp.sv
hdl/aud_dsp_top.sv
test/tb_aud_sram.sv
test/tb_aud_dsp.sv

//--- Bender.yml
package:
  name: aud_dsp

sources:
  - hdl/aud_mem_pkg.sv
  - hdl/aud_speed_pkg.sv
  - hdl/aud_lrck_sync.sv
  - hdl/aud_play_ctrl.sv
  - hdl/aud_addr_gen.sv
  - hdl/aud_interp.sv
  - hdl/aud_dsp_top.sv
  - target: test
    files:
      - test/tb_aud_sram.sv
      - test/tb_aud_dsp.sv
